// File: hdl/fft_types_pkg.sv
`default_nettype none

package fft_types_pkg;

	// One real or imaginary part
	localparam int SAMPLE_W = 16;

	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// Real part in the upper half, imaginary in the lower
	typedef logic [2*SAMPLE_W-1:0] cplx_t;

	// Twiddle format is Q1.14
	localparam int COEF_W = 16;
	localparam int COEF_FRAC = 14;

	typedef logic signed [COEF_W-1:0] coef_t;

endpackage

`default_nettype wire

// File: hdl/fft_ctrl_pkg.sv
`default_nettype none

package fft_ctrl_pkg;

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		CALC,
		UNLOAD
	} fft_state_e;

	// Upper bound on log2(N) for the pass counter width
	localparam int MAX_LOG_N = 12;

	typedef logic [$clog2(MAX_LOG_N)-1:0] pass_t;

endpackage

`default_nettype wire

// File: hdl/fft_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fft_bus_if #(
	parameter int N = 16
);

	// Host write port into the bank
	logic                                       wr_en;
	logic [$clog2(N)-1:0]                       wr_addr;
	fft_types_pkg::cplx_t                       wr_data;

	// Pass sequencing
	logic                                       start_pass;
	fft_ctrl_pkg::pass_t                        pass_idx;
	logic                                       pass_done;

	// Bin i of the bank sits at slice i
	logic [N*$bits(fft_types_pkg::cplx_t)-1:0]  bank;

	modport ctrl (
		output wr_en, wr_addr, wr_data, start_pass, pass_idx,
		input  pass_done, bank
	);

	modport regs (
		input  wr_en, wr_addr, wr_data, start_pass, pass_idx,
		output pass_done, bank
	);

endinterface

`default_nettype wire

// File: hdl/twiddle_rom.sv
`timescale 1ns/1ps
`default_nettype none

module twiddle_rom #(
	parameter int N = 16
) (
	input  logic [$clog2(N)-1:0] k,
	output fft_types_pkg::coef_t cos_val,
	output fft_types_pkg::coef_t sin_val
);

	localparam real PI = 3.14159265358979323846;
	localparam int CMAX = 2 ** (fft_types_pkg::COEF_W - 1) - 1;
	localparam int CMIN = -(2 ** (fft_types_pkg::COEF_W - 1));

	fft_types_pkg::coef_t cos_tab [N];
	fft_types_pkg::coef_t sin_tab [N];

	// Round half away from zero, then clamp
	function automatic fft_types_pkg::coef_t quant(input real v);
		real scaled;
		int q;
		scaled = v * (2.0 ** fft_types_pkg::COEF_FRAC);
		if (scaled >= 0.0)
			q = $rtoi(scaled + 0.5);
		else
			q = -$rtoi(0.5 - scaled);
		if (q > CMAX)
			q = CMAX;
		if (q < CMIN)
			q = CMIN;
		return fft_types_pkg::coef_t'(q);
	endfunction

	for (genvar i = 0; i < N; i++)
	begin : g_tab
		localparam real ANG = 2.0 * PI * i / N;
		// sin entry is negated since W = exp(-j*ang)
		localparam fft_types_pkg::coef_t COS_Q = quant($cos(ANG));
		localparam fft_types_pkg::coef_t SIN_Q = quant(-$sin(ANG));

		assign cos_tab[i] = COS_Q;
		assign sin_tab[i] = SIN_Q;
	end

	assign cos_val = cos_tab[k];
	assign sin_val = sin_tab[k];

endmodule

`default_nettype wire

// File: hdl/radix4_butterfly.sv
`timescale 1ns/1ps
`default_nettype none

module radix4_butterfly (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_valid,
	input  fft_types_pkg::cplx_t a0,
	input  fft_types_pkg::cplx_t a1,
	input  fft_types_pkg::cplx_t a2,
	input  fft_types_pkg::cplx_t a3,
	input  fft_types_pkg::coef_t w1_re,
	input  fft_types_pkg::coef_t w1_im,
	input  fft_types_pkg::coef_t w2_re,
	input  fft_types_pkg::coef_t w2_im,
	input  fft_types_pkg::coef_t w3_re,
	input  fft_types_pkg::coef_t w3_im,
	output logic                 out_valid,
	output fft_types_pkg::cplx_t y0,
	output fft_types_pkg::cplx_t y1,
	output fft_types_pkg::cplx_t y2,
	output fft_types_pkg::cplx_t y3
);

	localparam int SW = fft_types_pkg::SAMPLE_W;
	localparam int EW = SW + 2;
	localparam int PW = SW + fft_types_pkg::COEF_W + 1;
	localparam int FR = fft_types_pkg::COEF_FRAC;

	fft_types_pkg::cplx_t   a [4];
	fft_types_pkg::sample_t ar [4];
	fft_types_pkg::sample_t ai [4];
	logic signed [EW-1:0]   xr [4];
	logic signed [EW-1:0]   xi [4];
	fft_types_pkg::sample_t sr_q [4];
	fft_types_pkg::sample_t si_q [4];
	fft_types_pkg::coef_t   wr_q [1:3];
	fft_types_pkg::coef_t   wi_q [1:3];
	logic                   v1_q;
	logic signed [PW-1:0]   prod_re [1:3];
	logic signed [PW-1:0]   prod_im [1:3];
	fft_types_pkg::cplx_t   y_q [4];

	assign a[0] = a0;
	assign a[1] = a1;
	assign a[2] = a2;
	assign a[3] = a3;

	// Stage one forms the DIF sums with -j on the odd terms
	always_comb
	begin
		logic signed [EW-1:0] p02r;
		logic signed [EW-1:0] p02i;
		logic signed [EW-1:0] m02r;
		logic signed [EW-1:0] m02i;
		logic signed [EW-1:0] p13r;
		logic signed [EW-1:0] p13i;
		logic signed [EW-1:0] m13r;
		logic signed [EW-1:0] m13i;
		for (int m = 0; m < 4; m++)
		begin
			ar[m] = a[m][2*SW-1:SW];
			ai[m] = a[m][SW-1:0];
		end
		p02r = ar[0] + ar[2];
		p02i = ai[0] + ai[2];
		m02r = ar[0] - ar[2];
		m02i = ai[0] - ai[2];
		p13r = ar[1] + ar[3];
		p13i = ai[1] + ai[3];
		m13r = ar[1] - ar[3];
		m13i = ai[1] - ai[3];
		xr[0] = p02r + p13r;
		xi[0] = p02i + p13i;
		xr[1] = m02r + m13i;
		xi[1] = m02i - m13r;
		xr[2] = p02r - p13r;
		xi[2] = p02i - p13i;
		xr[3] = m02r - m13i;
		xi[3] = m02i + m13r;
	end

	// Dropping the two low bits is the scale by 1/4
	always_ff @(posedge clk)
	begin
		for (int m = 0; m < 4; m++)
		begin
			sr_q[m] <= xr[m][EW-1:2];
			si_q[m] <= xi[m][EW-1:2];
		end
		wr_q[1] <= w1_re;
		wi_q[1] <= w1_im;
		wr_q[2] <= w2_re;
		wi_q[2] <= w2_im;
		wr_q[3] <= w3_re;
		wi_q[3] <= w3_im;
	end

	// Stage two applies the twiddle multiply
	always_comb
	begin
		for (int m = 1; m < 4; m++)
		begin
			prod_re[m] = sr_q[m] * wr_q[m] - si_q[m] * wi_q[m];
			prod_im[m] = sr_q[m] * wi_q[m] + si_q[m] * wr_q[m];
		end
	end

	always_ff @(posedge clk)
	begin
		y_q[0] <= {sr_q[0], si_q[0]};
		for (int m = 1; m < 4; m++)
			y_q[m] <= {prod_re[m][FR +: SW], prod_im[m][FR +: SW]};
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			v1_q <= 1'b0;
			out_valid <= 1'b0;
		end
		else
		begin
			v1_q <= in_valid;
			out_valid <= v1_q;
		end
	end

	assign y0 = y_q[0];
	assign y1 = y_q[1];
	assign y2 = y_q[2];
	assign y3 = y_q[3];

	a_inputs_known: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> !$isunknown({a0, a1, a2, a3, w1_re, w1_im, w2_re, w2_im, w3_re, w3_im}));

endmodule

`default_nettype wire

// File: hdl/fft_reg_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fft_reg_stage #(
	parameter int N = 16
) (
	input  logic    clk,
	input  logic    rst_n,
	fft_bus_if.regs bus
);

	localparam int IDX_W = $clog2(N);
	localparam int NBF = N / 4;
	localparam int BF_W = (NBF > 1) ? $clog2(NBF) : 1;
	localparam int CW = $bits(fft_types_pkg::cplx_t);

	fft_types_pkg::cplx_t bank_q [N];
	fft_types_pkg::cplx_t snap_q [N];
	logic                 running_q;
	logic [BF_W-1:0]      cnt_q;
	logic [1:0]           last_q;
	logic                 done_q;
	logic                 issue;
	logic [BF_W-1:0]      pos;
	logic                 last_issue;
	logic                 pass_run;
	logic [IDX_W-1:0]     src_idx [4];
	logic [IDX_W-1:0]     dst_d1 [4];
	logic [IDX_W-1:0]     dst_d2 [4];
	logic [IDX_W-1:0]     tw_exp [1:3];
	fft_types_pkg::cplx_t bf_in [4];
	fft_types_pkg::cplx_t bf_out [4];
	fft_types_pkg::coef_t w_re [1:3];
	fft_types_pkg::coef_t w_im [1:3];
	logic                 bf_valid;

	// First butterfly goes out in the start_pass cycle itself
	assign issue = bus.start_pass | running_q;
	assign pos = running_q ? cnt_q : '0;
	assign last_issue = issue && (pos == BF_W'(NBF - 1));
	assign pass_run = running_q | (|last_q) | done_q;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			running_q <= 1'b0;
			cnt_q <= '0;
			last_q <= '0;
			done_q <= 1'b0;
		end
		else
		begin
			last_q <= {last_q[0], last_issue};
			done_q <= last_q[1];
			if (issue)
			begin
				running_q <= !last_issue;
				cnt_q <= pos + 1'b1;
			end
		end
	end

	assign bus.pass_done = done_q;

	// Group, offset and quarter spacing from the pass number
	always_comb
	begin
		int qsh;
		logic [IDX_W-1:0] pos_w;
		logic [IDX_W-1:0] kpos;
		logic [IDX_W-1:0] base;
		logic [IDX_W-1:0] tw_e;
		qsh = IDX_W - 2 - 2 * int'(bus.pass_idx);
		pos_w = IDX_W'(pos);
		kpos = pos_w & ((IDX_W'(1) << qsh) - 1'b1);
		base = (pos_w >> qsh) << (qsh + 2);
		for (int m = 0; m < 4; m++)
			src_idx[m] = base + kpos + (IDX_W'(m) << qsh);
		tw_e = kpos << (2 * int'(bus.pass_idx));
		tw_exp[1] = tw_e;
		tw_exp[2] = tw_e << 1;
		tw_exp[3] = tw_e + (tw_e << 1);
		// snapshot is not yet loaded in the start cycle
		for (int m = 0; m < 4; m++)
			bf_in[m] = running_q ? snap_q[src_idx[m]] : bank_q[src_idx[m]];
	end

	for (genvar m = 1; m < 4; m++)
	begin : g_rom
		twiddle_rom #(.N(N)) u_rom (
			.k       (tw_exp[m]),
			.cos_val (w_re[m]),
			.sin_val (w_im[m])
		);
	end

	radix4_butterfly u_bfly (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (issue),
		.a0        (bf_in[0]),
		.a1        (bf_in[1]),
		.a2        (bf_in[2]),
		.a3        (bf_in[3]),
		.w1_re     (w_re[1]),
		.w1_im     (w_im[1]),
		.w2_re     (w_re[2]),
		.w2_im     (w_im[2]),
		.w3_re     (w_re[3]),
		.w3_im     (w_im[3]),
		.out_valid (bf_valid),
		.y0        (bf_out[0]),
		.y1        (bf_out[1]),
		.y2        (bf_out[2]),
		.y3        (bf_out[3])
	);

	// Destinations follow the butterfly latency
	always_ff @(posedge clk)
	begin
		dst_d1 <= src_idx;
		dst_d2 <= dst_d1;
		if (bus.start_pass)
			snap_q <= bank_q;
	end

	always_ff @(posedge clk)
	begin
		if (bus.wr_en)
			bank_q[bus.wr_addr] <= bus.wr_data;
		if (bf_valid)
			for (int m = 0; m < 4; m++)
				bank_q[dst_d2[m]] <= bf_out[m];
	end

	always_comb
	begin
		for (int i = 0; i < N; i++)
			bus.bank[i*CW +: CW] = bank_q[i];
	end

	a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		bus.start_pass |-> !pass_run);

endmodule

`default_nettype wire

// File: hdl/fft.sv
`timescale 1ns/1ps
`default_nettype none

module fft #(
	parameter int N = 16
) (
	input  logic                                      clk,
	input  logic                                      rst_n,
	input  fft_types_pkg::sample_t                    data_in_re,
	input  fft_types_pkg::sample_t                    data_in_im,
	input  logic [$clog2(N)-1:0]                      addr,
	input  logic                                      insert_data,
	output logic [N*$bits(fft_types_pkg::cplx_t)-1:0] data_out,
	output logic                                      busy,
	output logic                                      fft_finish
);

	localparam int IDX_W = $clog2(N);
	localparam int CW = $bits(fft_types_pkg::cplx_t);
	localparam int NPASS = IDX_W / 2;

	fft_ctrl_pkg::fft_state_e state_q;
	fft_ctrl_pkg::pass_t      pass_q;
	logic                     start_q;
	logic                     host_wr;
	logic                     last_wr;

	fft_bus_if #(.N(N)) bus ();

	fft_reg_stage #(.N(N)) u_reg_stage (
		.clk   (clk),
		.rst_n (rst_n),
		.bus   (bus.regs)
	);

	// Base-4 digit reversal of a bin index
	function automatic int digit_rev(input int v);
		int r;
		r = 0;
		for (int d = 0; d < NPASS; d++)
			r = (r << 2) | ((v >> (2 * d)) & 3);
		return r;
	endfunction

	// Host writes only land while loading
	assign host_wr = insert_data &&
		(state_q == fft_ctrl_pkg::IDLE || state_q == fft_ctrl_pkg::LOAD);
	assign last_wr = host_wr && (addr == IDX_W'(N - 1));

	assign bus.wr_en = host_wr;
	assign bus.wr_addr = addr;
	assign bus.wr_data = {data_in_re, data_in_im};
	assign bus.start_pass = start_q;
	assign bus.pass_idx = pass_q;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state_q <= fft_ctrl_pkg::IDLE;
			pass_q <= '0;
			start_q <= 1'b0;
			busy <= 1'b0;
			fft_finish <= 1'b0;
			data_out <= '0;
		end
		else
		begin
			start_q <= 1'b0;
			fft_finish <= 1'b0;
			case (state_q)
				fft_ctrl_pkg::IDLE, fft_ctrl_pkg::LOAD:
				begin
					if (host_wr)
					begin
						busy <= 1'b1;
						state_q <= fft_ctrl_pkg::LOAD;
						if (last_wr)
						begin
							state_q <= fft_ctrl_pkg::CALC;
							pass_q <= '0;
							start_q <= 1'b1;
						end
					end
				end
				fft_ctrl_pkg::CALC:
				begin
					if (bus.pass_done)
					begin
						if (pass_q == fft_ctrl_pkg::pass_t'(NPASS - 1))
							state_q <= fft_ctrl_pkg::UNLOAD;
						else
						begin
							pass_q <= pass_q + 1'b1;
							start_q <= 1'b1;
						end
					end
				end
				fft_ctrl_pkg::UNLOAD:
				begin
					// Bank holds bins in digit-reversed order
					for (int i = 0; i < N; i++)
						data_out[i*CW +: CW] <= bus.bank[digit_rev(i)*CW +: CW];
					fft_finish <= 1'b1;
					busy <= 1'b0;
					state_q <= fft_ctrl_pkg::IDLE;
				end
				default:
					state_q <= fft_ctrl_pkg::IDLE;
			endcase
		end
	end

	a_finish_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
		fft_finish |-> !busy);

	a_start_in_calc: assert property (@(posedge clk) disable iff (!rst_n)
		bus.start_pass |-> state_q == fft_ctrl_pkg::CALC);

endmodule

`default_nettype wire

// File: dv/fft_model.svh
`ifndef FFT_MODEL_SVH
`define FFT_MODEL_SVH

function automatic int wrap_sample(input longint v);
	longint t;
	t = v & 64'hffff;
	if (t >= 32768)
		t = t - 65536;
	return int'(t);
endfunction

// Half away from zero, then saturate to the coefficient range
function automatic int quant_coef(input real v);
	real scaled;
	int q;
	int lim;
	scaled = v * (2.0 ** fft_types_pkg::COEF_FRAC);
	q = int'($floor(((scaled < 0.0) ? -scaled : scaled) + 0.5));
	if (scaled < 0.0)
		q = -q;
	lim = 1 << (fft_types_pkg::COEF_W - 1);
	if (q > lim - 1)
		q = lim - 1;
	if (q < -lim)
		q = -lim;
	return q;
endfunction

function automatic int cos_coef(input int e);
	return quant_coef($cos(6.283185307179586 * real'(e) / real'(N)));
endfunction

// W = exp(-j*ang), so the imaginary part is -sin
function automatic int sin_coef(input int e);
	return quant_coef(-$sin(6.283185307179586 * real'(e) / real'(N)));
endfunction

function automatic int digit_reverse(input int v);
	int r;
	int t;
	r = 0;
	t = v;
	for (int d = 0; d < NPASS; d++)
	begin
		r = r * 4 + t % 4;
		t = t / 4;
	end
	return r;
endfunction

// Reference radix-4 DIF transform of img_re/img_im into natural-order exp_re/exp_im
function automatic void run_model();
	int br [N];
	int bi [N];
	int ar [4];
	int ai [4];
	int sr [4];
	int si [4];
	int idx [4];
	int q;
	int step;
	int e;
	longint prod_r;
	longint prod_i;
	for (int i = 0; i < N; i++)
	begin
		br[i] = img_re[i];
		bi[i] = img_im[i];
	end
	q = N / 4;
	step = 1;
	for (int p = 0; p < NPASS; p++)
	begin
		for (int g = 0; g < N; g += 4 * q)
		begin
			for (int k = 0; k < q; k++)
			begin
				for (int m = 0; m < 4; m++)
				begin
					idx[m] = g + k + m * q;
					ar[m] = br[idx[m]];
					ai[m] = bi[idx[m]];
				end
				sr[0] = ar[0] + ar[1] + ar[2] + ar[3];
				si[0] = ai[0] + ai[1] + ai[2] + ai[3];
				sr[1] = ar[0] + ai[1] - ar[2] - ai[3];
				si[1] = ai[0] - ar[1] - ai[2] + ar[3];
				sr[2] = ar[0] - ar[1] + ar[2] - ar[3];
				si[2] = ai[0] - ai[1] + ai[2] - ai[3];
				sr[3] = ar[0] - ai[1] - ar[2] + ai[3];
				si[3] = ai[0] + ar[1] - ai[2] - ar[3];
				for (int m = 0; m < 4; m++)
				begin
					sr[m] = sr[m] >>> 2;
					si[m] = si[m] >>> 2;
					e = (m * k * step) % N;
					prod_r = longint'(sr[m]) * cos_coef(e) - longint'(si[m]) * sin_coef(e);
					prod_i = longint'(sr[m]) * sin_coef(e) + longint'(si[m]) * cos_coef(e);
					br[idx[m]] = wrap_sample(prod_r >>> fft_types_pkg::COEF_FRAC);
					bi[idx[m]] = wrap_sample(prod_i >>> fft_types_pkg::COEF_FRAC);
				end
			end
		end
		q = q / 4;
		step = step * 4;
	end
	for (int i = 0; i < N; i++)
	begin
		exp_re[i] = br[digit_reverse(i)];
		exp_im[i] = bi[digit_reverse(i)];
	end
endfunction

`endif

// File: dv/fft_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fft_tb;

	localparam int N = 16;
	localparam int IDX_W = $clog2(N);
	localparam int NPASS = IDX_W / 2;
	localparam int SW = fft_types_pkg::SAMPLE_W;
	localparam int CW = 2 * SW;
	localparam int CLK_PERIOD = 4;
	localparam int LATENCY = NPASS * (N / 4 + 3) + 2;
	localparam int NRAND = 40;
	localparam int NFRAMES = NRAND + 3;
	localparam int FRAME_CYCLES = N + NPASS * (N / 4 + 3) + 20;
	localparam int MARGIN_CYCLES = NFRAMES * (N + 8) + 200;
	localparam int SEED = 98514;

	logic                   clk;
	logic                   rst_n;
	fft_types_pkg::sample_t data_in_re;
	fft_types_pkg::sample_t data_in_im;
	logic [IDX_W-1:0]       addr;
	logic                   insert_data;
	logic [N*CW-1:0]        data_out;
	logic                   busy;
	logic                   fft_finish;

	int              img_re [N];
	int              img_im [N];
	int              exp_re [N];
	int              exp_im [N];
	logic [N*CW-1:0] prev_out;
	logic            prev_busy;
	logic            prev_finish;
	logic            prev_insert;
	logic            prev_rst_n;

	fft #(.N(N)) dut0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.data_in_re  (data_in_re),
		.data_in_im  (data_in_im),
		.addr        (addr),
		.insert_data (insert_data),
		.data_out    (data_out),
		.busy        (busy),
		.fft_finish  (fft_finish)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(NFRAMES * FRAME_CYCLES * CLK_PERIOD + MARGIN_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before all frames completed");
		$display("Some tests failed");
		$fatal(1);
	end

	task automatic value_error(input string sig, input int expected, input int actual);
		$display("** Error at %0t ns: %s expected %0d, got %0d", $time, sig, expected, actual);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic fail_run(input string what);
		$display("At %0t ns: %s", $time, what);
		$display("Some tests failed");
		$fatal(1);
	endtask

	// Control rules, sampled away from the active edge
	always @(negedge clk)
	begin
		if (rst_n && prev_rst_n)
		begin
			if (prev_insert && !prev_busy)
				assert (busy) else fail_run("busy did not rise on the first insert of a frame");
			if (fft_finish)
			begin
				assert (!prev_finish) else fail_run("fft_finish stayed high for two cycles");
				assert (prev_busy && !busy) else fail_run("fft_finish did not match busy falling");
			end
			if (prev_busy && !busy)
				assert (fft_finish) else fail_run("busy fell without fft_finish");
			if (!fft_finish)
				assert (data_out == prev_out) else fail_run("data_out changed between finishes");
		end
		prev_out = data_out;
		prev_busy = busy;
		prev_finish = fft_finish;
		prev_insert = insert_data;
		prev_rst_n = rst_n;
	end

	task automatic write_sample(input int a, input int re, input int im);
		@(posedge clk);
		insert_data <= 1'b1;
		addr <= IDX_W'(a);
		data_in_re <= fft_types_pkg::sample_t'(re);
		data_in_im <= fft_types_pkg::sample_t'(im);
		img_re[a] = re;
		img_im[a] = im;
	endtask

	function automatic int rand_sample();
		fft_types_pkg::sample_t s;
		s = fft_types_pkg::sample_t'($urandom);
		return int'(s);
	endfunction

	// Every address gets written in shuffled order with N-1 last
	task automatic load_frame(input bit impulse);
		int order [N-1];
		int j;
		int tmp;
		int extra;
		for (int i = 0; i < N - 1; i++)
			order[i] = i;
		for (int i = N - 2; i > 0; i--)
		begin
			j = $urandom_range(i, 0);
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int i = 0; i < N - 1; i++)
		begin
			if (impulse)
				write_sample(order[i], (order[i] == 0) ? 8192 : 0, 0);
			else
				write_sample(order[i], rand_sample(), rand_sample());
			if (!impulse && $urandom_range(3, 0) == 0)
			begin
				@(posedge clk);
				insert_data <= 1'b0;
			end
		end
		extra = impulse ? 0 : $urandom_range(3, 0);
		for (int i = 0; i < extra; i++)
			write_sample($urandom_range(N - 2, 0), rand_sample(), rand_sample());
		if (impulse)
			write_sample(N - 1, 0, 0);
		else
			write_sample(N - 1, rand_sample(), rand_sample());
	endtask

	// Optional stray inserts stay well inside CALC
	task automatic wait_finish(input bit noise);
		int cycles;
		logic drive;
		cycles = 0;
		do
		begin
			@(posedge clk);
			drive = noise && (cycles < NPASS * (N / 4)) && ($urandom_range(1, 0) == 1);
			insert_data <= drive;
			addr <= IDX_W'($urandom_range(N - 1, 0));
			data_in_re <= fft_types_pkg::sample_t'($urandom);
			data_in_im <= fft_types_pkg::sample_t'($urandom);
			@(negedge clk);
			cycles++;
			assert (cycles <= LATENCY + 2) else fail_run("fft_finish missing after the last write");
		end
		while (!fft_finish);
		assert (cycles >= N / 4) else fail_run("fft_finish arrived too early");
	endtask

	task automatic check_bins();
		int got_re;
		int got_im;
		for (int i = 0; i < N; i++)
		begin
			got_re = int'(fft_types_pkg::sample_t'(data_out[i*CW+SW +: SW]));
			got_im = int'(fft_types_pkg::sample_t'(data_out[i*CW +: SW]));
			assert (got_re == exp_re[i])
			else value_error($sformatf("data_out[%0d].re", i), exp_re[i], got_re);
			assert (got_im == exp_im[i])
			else value_error($sformatf("data_out[%0d].im", i), exp_im[i], got_im);
		end
	endtask

	initial
	begin
		rst_n = 1'b0;
		insert_data = 1'b0;
		addr = '0;
		data_in_re = '0;
		data_in_im = '0;
		prev_rst_n = 1'b0;
		void'($urandom(SEED));
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		// Impulse gives a flat spectrum of 8192/16
		load_frame(1'b1);
		wait_finish(1'b0);
		for (int i = 0; i < N; i++)
		begin
			exp_re[i] = 512;
			exp_im[i] = 0;
		end
		check_bins();

		for (int f = 0; f < NRAND; f++)
		begin
			load_frame(1'b0);
			run_model();
			wait_finish(f % 4 == 3);
			check_bins();
		end

		// Reset in the middle of CALC
		load_frame(1'b0);
		@(posedge clk);
		insert_data <= 1'b0;
		repeat (N / 4) @(posedge clk);
		rst_n <= 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		assert (!busy) else value_error("busy", 0, int'(busy));
		assert (!fft_finish) else value_error("fft_finish", 0, int'(fft_finish));
		for (int i = 0; i < N; i++)
			assert (data_out[i*CW +: CW] == '0)
			else value_error($sformatf("data_out[%0d]", i), 0, int'(data_out[i*CW +: CW]));
		@(posedge clk);
		rst_n <= 1'b1;

		load_frame(1'b0);
		run_model();
		wait_finish(1'b0);
		check_bins();

		$display("All tests passed");
		$finish;
	end

`include "fft_model.svh"

endmodule

`default_nettype wire

// File: filelist.f
+incdir+dv
hdl/fft_types_pkg.sv
hdl/fft_ctrl_pkg.sv
hdl/fft_bus_if.sv
hdl/twiddle_rom.sv
hdl/radix4_butterfly.sv
hdl/fft_reg_stage.sv
hdl/fft.sv
dv/fft_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the FFT testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module fft_tb -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vfft_tb 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'All tests passed'; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
